//--- all.f
design/game_pkg.sv
design/link_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/link_protocol.sv
design/game_control.sv
design/fleet_damage.sv
design/battle_link_top.sv
verification/battle_link_tb.sv

//--- design/battle_link_top.sv
`timescale 1ns/10ps

module battle_link_top import game_pkg::*, link_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         rx,
    input  logic         game_button,
    input  logic         menu_button,
    input  logic         victory_button,
    input  logic         game_over_button,
    input  logic         mouse_left,
    input  coord_t       xpos,
    input  coord_t       ypos,
    output logic         tx,
    output logic [15:0]  led,
    output game_status_t status
);

    link_event_t events;
    opp_status_t opp;
    logic        round_clear;
    logic        sunk;
    logic        tx_send;
    logic        tx_busy;
    msg_t        tx_data;
    logic        rx_valid;
    msg_t        rx_data;

    game_control u_game_control (
        .clk(clk), .rst(rst),
        .game_button(game_button), .menu_button(menu_button),
        .game_over_button(game_over_button), .mouse_left(mouse_left),
        .xpos(xpos), .ypos(ypos), .opp(opp), .sunk(sunk),
        .events(events), .round_clear(round_clear), .status(status)
    );

    // victory_button injects test hits
    fleet_damage u_fleet_damage (
        .clk(clk), .rst(rst), .clear(round_clear),
        .hit(opp.opp_hit), .test_hit(victory_button),
        .led(led), .sunk(sunk)
    );

    link_protocol u_link_protocol (
        .clk(clk), .rst(rst), .events(events), .round_clear(round_clear),
        .rx_valid(rx_valid), .rx_data(rx_data), .tx_busy(tx_busy),
        .tx_send(tx_send), .tx_data(tx_data), .opp(opp)
    );

    uart_tx u_uart_tx (
        .clk(clk), .rst(rst), .send(tx_send), .data(tx_data),
        .tx(tx), .busy(tx_busy)
    );

    uart_rx u_uart_rx (
        .clk(clk), .rst(rst), .rx(rx), .valid(rx_valid), .data(rx_data)
    );

endmodule

//--- design/fleet_damage.sv
`timescale 1ns/10ps

module fleet_damage import game_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear,
    input  logic                   hit,
    input  logic                   test_hit,
    output logic [FLEET_CELLS-1:0] led,
    output logic                   sunk
);

    hit_count_t hits;

    // saturates at a full fleet
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            hits <= '0;
            sunk <= 1'b0;
        end else begin
            if ((hit || test_hit) && hits != hit_count_t'(FLEET_CELLS))
                hits <= hits + 1'b1;
            sunk <= (hits == hit_count_t'(FLEET_CELLS));
        end
    end

    // thermometer bar
    always_comb begin
        for (int i = 0; i < FLEET_CELLS; i++)
            led[i] = (hits > hit_count_t'(i));
    end

endmodule

//--- design/game_control.sv
`timescale 1ns/10ps

module game_control import game_pkg::*, link_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         game_button,
    input  logic         menu_button,
    input  logic         game_over_button,
    input  logic         mouse_left,
    input  coord_t       xpos,
    input  coord_t       ypos,
    input  opp_status_t  opp,
    input  logic         sunk,
    output link_event_t  events,
    output logic         round_clear,
    output game_status_t status
);

    game_state_t state;
    game_state_t state_next;
    link_event_t events_next;
    logic        mouse_prev;
    logic        click;
    logic        in_board;

    assign click    = mouse_left && !mouse_prev;
    assign in_board = (xpos >= coord_t'(LEFT_H_LINE)) && (xpos <= coord_t'(RIGHT_H_LINE))
                   && (ypos >= coord_t'(TOP_V_LINE)) && (ypos <= coord_t'(BOTTOM_V_LINE));

    always_comb begin
        state_next  = state;
        events_next = '0;
        if (menu_button) begin
            state_next = ST_MENU;
        end else begin
            case (state)
                ST_MENU: if (game_button) begin
                    events_next.ready = 1'b1;
                    state_next = ST_WAIT;
                end
                ST_WAIT: if (opp.opp_ready) state_next = ST_PLAY;
                ST_PLAY: begin
                    if (sunk || game_over_button) begin
                        events_next.lost = 1'b1;
                        state_next = ST_LOST;
                    end else if (opp.opp_lost) begin
                        state_next = ST_WON;
                    end else if (click && in_board) begin
                        events_next.shot = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_MENU;
            mouse_prev  <= 1'b0;
            events      <= '0;
            round_clear <= 1'b0;
            status      <= '0;
        end else begin
            state       <= state_next;
            mouse_prev  <= mouse_left;
            events      <= events_next;
            round_clear <= menu_button;
            status.playing   <= (state_next == ST_PLAY);
            status.game_over <= (state_next == ST_LOST);
            status.victory   <= (state_next == ST_WON);
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {ST_MENU, ST_WAIT, ST_PLAY, ST_LOST, ST_WON})
        else $error("game_control: illegal state %0d", state);

endmodule

//--- design/game_pkg.sv
package game_pkg;

    // opponent board area on screen in pixels
    localparam int TOP_V_LINE    = 317;
    localparam int BOTTOM_V_LINE = 617;
    localparam int LEFT_H_LINE   = 361;
    localparam int RIGHT_H_LINE  = 661;

    // hits needed to sink the whole fleet
    localparam int FLEET_CELLS = 16;

    typedef logic [11:0] coord_t;
    typedef logic [4:0]  hit_count_t;

    typedef enum logic [2:0] {
        ST_MENU,
        ST_WAIT,
        ST_PLAY,
        ST_LOST,
        ST_WON
    } game_state_t;

    typedef struct packed {
        logic playing;
        logic game_over;
        logic victory;
    } game_status_t;

endpackage

//--- design/link_pkg.sv
package link_pkg;

    // serial bit time in clk cycles
    localparam int CLKS_PER_BIT = 16;
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

    typedef logic [7:0] msg_t;

    // message codes on the link
    localparam msg_t MSG_READY = 8'hA1;
    localparam msg_t MSG_HIT   = 8'hA2;
    localparam msg_t MSG_OVER  = 8'hA3;

    // one-cycle pulses of local events
    typedef struct packed {
        logic ready;
        logic shot;
        logic lost;
    } link_event_t;

    typedef struct packed {
        logic opp_ready;
        logic opp_hit;
        logic opp_lost;
    } opp_status_t;

endpackage

//--- design/link_protocol.sv
`timescale 1ns/10ps

module link_protocol import link_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  link_event_t events,
    input  logic        round_clear,
    input  logic        rx_valid,
    input  msg_t        rx_data,
    input  logic        tx_busy,
    output logic        tx_send,
    output msg_t        tx_data,
    output opp_status_t opp
);

    link_event_t pending;
    link_event_t sent;

    // priority is lost, then ready, then shot
    always_comb begin
        sent    = '0;
        tx_data = MSG_READY;
        if (pending.lost) begin
            tx_data = MSG_OVER;
            sent.lost = !tx_busy;
        end else if (pending.ready) begin
            tx_data = MSG_READY;
            sent.ready = !tx_busy;
        end else if (pending.shot) begin
            tx_data = MSG_HIT;
            sent.shot = !tx_busy;
        end
    end

    assign tx_send = |sent;

    // repeated events merge into the flag
    always_ff @(posedge clk) begin
        if (rst)
            pending <= '0;
        else
            pending <= (pending & ~sent) | events;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            opp <= '0;
        end else begin
            opp.opp_hit  <= 1'b0;
            opp.opp_lost <= 1'b0;
            if (rx_valid) begin
                case (rx_data)
                    MSG_READY: opp.opp_ready <= 1'b1;
                    MSG_HIT:   opp.opp_hit   <= 1'b1;
                    MSG_OVER:  opp.opp_lost  <= 1'b1;
                    default: ;
                endcase
            end
            if (round_clear)
                opp.opp_ready <= 1'b0;
        end
    end

    a_send_taken: assert property (@(posedge clk) disable iff (rst) tx_send |=> tx_busy)
        else $error("link_protocol: transmitter did not go busy after tx_send");

endmodule

//--- design/uart_rx.sv
`timescale 1ns/10ps

module uart_rx import link_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic rx,
    output logic valid,
    output msg_t data
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_WAIT
    } rx_state_t;

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic [BIT_CNT_W-1:0] clk_cnt;
    logic [2:0]           bit_idx;
    logic                 bit_end;

    assign bit_end = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            valid   <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync)
                        state <= RX_START;
                end
                RX_START: begin
                    // confirm start bit at mid-bit
                    if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        valid   <= rx_sync;
                        // wait for line idle after a bad stop bit
                        state   <= rx_sync ? RX_IDLE : RX_WAIT;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_WAIT: begin
                    if (rx_sync)
                        state <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end)
            data <= {rx_sync, data[7:1]};
    end

endmodule

//--- design/uart_tx.sv
`timescale 1ns/10ps

module uart_tx import link_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic send,
    input  msg_t data,
    output logic tx,
    output logic busy
);

    logic [BIT_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_cnt;
    // data bits with the stop bit on top
    logic [8:0]           shreg;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx      <= 1'b1;
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (send) begin
                // start bit goes out next cycle
                tx      <= 1'b0;
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
                tx   <= 1'b1;
            end else begin
                tx      <= shreg[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && send) begin
            shreg <= {1'b1, data};
        end else if (busy && clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

    a_no_send_while_busy: assert property (@(posedge clk) disable iff (rst) send |-> !busy)
        else $error("uart_tx: send strobe while frame in progress");

endmodule

//--- verification/battle_link_tb.sv
`timescale 1ns/10ps

module battle_link_tb import game_pkg::*, link_pkg::*; ();

    localparam int FRAME_CLKS    = 10 * CLKS_PER_BIT;
    localparam int QUIET_CLKS    = FRAME_CLKS + 40;
    localparam int START_TIMEOUT = 4 * FRAME_CLKS;
    localparam int SETTLE_CLKS   = 8;
    localparam int BTN_GAME      = 0;
    localparam int BTN_MENU      = 1;
    localparam int MID_X         = (LEFT_H_LINE + RIGHT_H_LINE) / 2;
    localparam int MID_Y         = (TOP_V_LINE + BOTTOM_V_LINE) / 2;

    localparam game_status_t S_NONE = game_status_t'(3'b000);
    localparam game_status_t S_PLAY = game_status_t'(3'b100);
    localparam game_status_t S_LOST = game_status_t'(3'b010);
    localparam game_status_t S_WON  = game_status_t'(3'b001);

    typedef enum logic [2:0] {
        T_RESET, T_READY, T_SHOTS, T_EDGES, T_HITS, T_ROUND2, T_NOISE
    } test_t;

    typedef enum logic [2:0] {
        K_IDLE, K_RX, K_BAD, K_BTN, K_CLICK
    } step_kind_t;

    typedef struct packed {
        test_t        test;
        step_kind_t   kind;
        logic [23:0]  arg;
        game_status_t status;
        logic [15:0]  led;
        logic         tx_check;
        msg_t         tx_byte;
    } step_t;

    logic         clk;
    logic         rst;
    logic         rx;
    logic         game_button;
    logic         menu_button;
    logic         victory_button;
    logic         game_over_button;
    logic         mouse_left;
    coord_t       xpos;
    coord_t       ypos;
    logic         tx;
    logic [15:0]  led;
    game_status_t status;

    step_t table_q[$];
    int    checks;
    int    value_errs;
    int    other_errs;

    battle_link_top DUT (
        .clk(clk), .rst(rst), .rx(rx),
        .game_button(game_button), .menu_button(menu_button),
        .victory_button(victory_button), .game_over_button(game_over_button),
        .mouse_left(mouse_left), .xpos(xpos), .ypos(ypos),
        .tx(tx), .led(led), .status(status)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic step_t mk(test_t t, step_kind_t k, logic [23:0] arg,
                                 game_status_t st, logic [15:0] leds, logic chk, msg_t b);
        step_t s;
        s.test     = t;
        s.kind     = k;
        s.arg      = arg;
        s.status   = st;
        s.led      = leds;
        s.tx_check = chk;
        s.tx_byte  = b;
        return s;
    endfunction

    function automatic logic [23:0] at(int x, int y);
        return {coord_t'(x), coord_t'(y)};
    endfunction

    // n hits light the low n leds
    function automatic logic [15:0] thermo(int n);
        return 16'((17'd1 << n) - 17'd1);
    endfunction

    task automatic log_mismatch(input string name, input int idx, input string field,
                                input logic [15:0] exp, input logic [15:0] act);
        value_errs++;
        $display("ERROR %s step %0d %s: expected %h, got %h", name, idx, field, exp, act);
    endtask

    task automatic log_problem(input string what);
        other_errs++;
        $display("%s", what);
    endtask

    task automatic build_table();
        table_q.push_back(mk(T_RESET, K_IDLE, 200, S_NONE, 16'h0, 1'b0, 8'h00));
        table_q.push_back(mk(T_READY, K_BTN, BTN_GAME, S_NONE, 16'h0, 1'b1, MSG_READY));
        table_q.push_back(mk(T_READY, K_RX, MSG_READY, S_PLAY, 16'h0, 1'b0, 8'h00));
        // corners of the board are inside
        table_q.push_back(mk(T_SHOTS, K_CLICK, at(LEFT_H_LINE, TOP_V_LINE), S_PLAY, 16'h0,
                             1'b1, MSG_HIT));
        table_q.push_back(mk(T_SHOTS, K_CLICK, at(RIGHT_H_LINE, BOTTOM_V_LINE), S_PLAY, 16'h0,
                             1'b1, MSG_HIT));
        table_q.push_back(mk(T_EDGES, K_CLICK, at(LEFT_H_LINE - 1, MID_Y), S_PLAY, 16'h0,
                             1'b0, 8'h00));
        table_q.push_back(mk(T_EDGES, K_CLICK, at(RIGHT_H_LINE + 1, MID_Y), S_PLAY, 16'h0,
                             1'b0, 8'h00));
        table_q.push_back(mk(T_EDGES, K_CLICK, at(MID_X, TOP_V_LINE - 1), S_PLAY, 16'h0,
                             1'b0, 8'h00));
        table_q.push_back(mk(T_EDGES, K_CLICK, at(MID_X, BOTTOM_V_LINE + 1), S_PLAY, 16'h0,
                             1'b0, 8'h00));
        for (int n = 1; n < FLEET_CELLS; n++)
            table_q.push_back(mk(T_HITS, K_RX, MSG_HIT, S_PLAY, thermo(n), 1'b0, 8'h00));
        // last cell sinks the fleet
        table_q.push_back(mk(T_HITS, K_RX, MSG_HIT, S_LOST, thermo(FLEET_CELLS), 1'b1, MSG_OVER));
        table_q.push_back(mk(T_ROUND2, K_BTN, BTN_MENU, S_NONE, 16'h0, 1'b0, 8'h00));
        table_q.push_back(mk(T_ROUND2, K_BTN, BTN_GAME, S_NONE, 16'h0, 1'b1, MSG_READY));
        table_q.push_back(mk(T_ROUND2, K_RX, MSG_READY, S_PLAY, 16'h0, 1'b0, 8'h00));
        table_q.push_back(mk(T_NOISE, K_BAD, MSG_HIT, S_PLAY, 16'h0, 1'b0, 8'h00));
        table_q.push_back(mk(T_NOISE, K_RX, 8'h55, S_PLAY, 16'h0, 1'b0, 8'h00));
        table_q.push_back(mk(T_NOISE, K_BAD, MSG_OVER, S_PLAY, 16'h0, 1'b0, 8'h00));
        table_q.push_back(mk(T_ROUND2, K_RX, MSG_OVER, S_WON, 16'h0, 1'b0, 8'h00));
    endtask

    task automatic drive_bit(input logic v);
        @(posedge clk);
        rx <= v;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    // 8N1 frame plus two idle bit times
    task automatic send_frame(input msg_t b, input logic stop);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++)
            drive_bit(b[i]);
        drive_bit(stop);
        drive_bit(1'b1);
        drive_bit(1'b1);
    endtask

    task automatic press(input int which);
        @(posedge clk);
        game_button <= (which == BTN_GAME);
        menu_button <= (which == BTN_MENU);
        @(posedge clk);
        game_button <= 1'b0;
        menu_button <= 1'b0;
    endtask

    task automatic click(input coord_t x, input coord_t y);
        @(posedge clk);
        xpos       <= x;
        ypos       <= y;
        mouse_left <= 1'b1;
        repeat (2) @(posedge clk);
        mouse_left <= 1'b0;
        @(posedge clk);
    endtask

    // tx is sampled mid-bit on the falling edge
    task automatic capture_frame(output msg_t b, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        b  = '0;
        do begin
            @(negedge clk);
            n++;
        end while (tx !== 1'b0 && n < START_TIMEOUT);
        assert (tx === 1'b0)
            else log_problem("no frame started on tx before the timeout");
        if (tx !== 1'b0)
            return;
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        assert (tx === 1'b0)
            else log_problem("start bit on tx ended before mid-bit");
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        assert (tx === 1'b1)
            else log_problem("stop bit on tx was low");
        ok = 1'b1;
    endtask

    task automatic watch_quiet(input int cycles, output bit quiet);
        quiet = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            if (tx !== 1'b1)
                quiet = 1'b0;
        end
    endtask

    task automatic apply(input step_t s, input int idx);
        msg_t got;
        bit   ok;
        bit   quiet;
        int   n;
        fork
            begin
                case (s.kind)
                    K_IDLE:  repeat (s.arg) @(posedge clk);
                    K_RX:    send_frame(msg_t'(s.arg), 1'b1);
                    K_BAD:   send_frame(msg_t'(s.arg), 1'b0);
                    K_BTN:   press(int'(s.arg));
                    default: click(coord_t'(s.arg[23:12]), coord_t'(s.arg[11:0]));
                endcase
            end
            begin
                if (s.tx_check) begin
                    capture_frame(got, ok);
                    if (ok) begin
                        checks++;
                        assert (got === s.tx_byte)
                            else log_mismatch(s.test.name(), idx, "tx byte", s.tx_byte, got);
                    end
                end else begin
                    watch_quiet(QUIET_CLKS, quiet);
                    checks++;
                    assert (quiet)
                        else log_problem($sformatf("step %0d: a tx frame started unexpectedly",
                                                   idx));
                end
            end
        join
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((status !== s.status || led !== s.led) && n < SETTLE_CLKS);
        checks += 2;
        assert (status === s.status)
            else log_mismatch(s.test.name(), idx, "status", 16'(s.status), 16'(status));
        assert (led === s.led)
            else log_mismatch(s.test.name(), idx, "led", s.led, led);
    endtask

    initial begin
        checks           = 0;
        value_errs       = 0;
        other_errs       = 0;
        rst              = 1'b1;
        rx               = 1'b1;
        game_button      = 1'b0;
        menu_button      = 1'b0;
        victory_button   = 1'b0;
        game_over_button = 1'b0;
        mouse_left       = 1'b0;
        xpos             = '0;
        ypos             = '0;
        build_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checks++;
        assert (tx === 1'b1)
            else log_problem("tx is not idle high after reset");
        foreach (table_q[i])
            apply(table_q[i], i);
        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
